// ==== Bender.yml ====
package:
  name: spiMemory

sources:
  - include_dirs:
      - design
    files:
      - design/spiMemPkg.sv
      - design/inputConditioner.sv
      - design/shiftRegister.sv
      - design/dataMemory.sv
      - design/spiMemFsm.sv
      - design/spiMemory.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tbSpiMemory.sv

// ==== design/dataMemory.sv ====
// Byte-wide memory with address latch, written synchronously and read combinationally
`timescale 1ns/1ps
`include "spiMemConfig_config.svh"

module dataMemory
    import spiMemPkg::*;
(
    input  logic    perEdge,
    input  logic    rstN,
    input  logic    addrWe,
    input  spiAddrT addrIn,
    input  logic    writeEn,
    input  spiDataT writeData,
    output spiDataT readData
);

    spiAddrT addrQ;
    spiDataT mem [`SPI_MEM_DEPTH];

    // ------------------------------
    // Address latch
    // ------------------------------
    always_ff @(posedge perEdge or negedge rstN) begin
        if (!rstN) begin
            addrQ <= '0;
        end else if (addrWe) begin
            addrQ <= addrIn;    // Held for the rest of the transaction
        end
    end

    // Array starts out all zero
    always_ff @(posedge perEdge or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `SPI_MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (writeEn) begin
            mem[addrQ] <= writeData;
        end
    end

    assign readData = mem[addrQ];

endmodule

// ==== design/inputConditioner.sv ====
// Brings one asynchronous SPI pin into the perEdge domain and flags its edges
`timescale 1ns/1ps
`include "spiMemConfig_config.svh"

module inputConditioner (
    input  logic perEdge,
    input  logic rstN,
    input  logic pin,
    output logic level,
    output logic posEdge,
    output logic negEdge
);

    localparam int Stages = `SPI_SYNC_STAGES;

    logic [Stages-1:0] syncQ;
    logic              histQ;

    // ------------------------------
    // Synchronizer and history
    // ------------------------------
    always_ff @(posedge perEdge or negedge rstN) begin
        if (!rstN) begin
            syncQ <= '0;
            histQ <= 1'b0;
        end else begin
            syncQ <= {syncQ[Stages-2:0], pin};  // Pin enters at bit 0
            histQ <= syncQ[Stages-1];
        end
    end

    assign level = syncQ[Stages-1];

    // One perEdge cycle wide pulses
    assign posEdge = level & ~histQ;
    assign negEdge = ~level & histQ;

endmodule

// ==== design/shiftRegister.sv ====
// Byte shift register for the SPI memory, serial in and out with parallel load
`timescale 1ns/1ps
`include "spiMemConfig_config.svh"

module shiftRegister
    import spiMemPkg::*;
(
    input  logic    perEdge,
    input  logic    rstN,
    input  logic    shiftEn,
    input  logic    serialIn,
    input  logic    loadEn,
    input  spiDataT loadData,
    output spiDataT parallelOut,
    output logic    serialOut
);

    localparam int Msb = `SPI_DATA_BITS - 1;

    spiDataT shiftQ;

    // ------------------------------
    // Load beats shift
    // ------------------------------
    always_ff @(posedge perEdge or negedge rstN) begin
        if (!rstN) begin
            shiftQ <= '0;
        end else if (loadEn) begin
            shiftQ <= loadData;                     // Memory byte for a read
        end else if (shiftEn) begin
            shiftQ <= {shiftQ[Msb-1:0], serialIn};  // Toward the MSB
        end
    end

    assign parallelOut = shiftQ;
    assign serialOut   = shiftQ[Msb];   // Drives miso

endmodule

// ==== design/spiMemConfig_config.svh ====
// Size settings for the SPI slave memory, included by every RTL module and the testbench
`ifndef SPI_MEM_CONFIG_SVH
`define SPI_MEM_CONFIG_SVH

// ------------------------------
// Memory geometry
// ------------------------------
`define SPI_ADDR_BITS 7         // Command address field
`define SPI_DATA_BITS 8         // One byte per location
`define SPI_MEM_DEPTH 128       // 2**SPI_ADDR_BITS locations

// ------------------------------
// Pin conditioning
// ------------------------------
// Flops between an SPI pin and the perEdge domain
`define SPI_SYNC_STAGES 2

`endif

// ==== design/spiMemFsm.sv ====
// Transaction controller for the SPI memory, sequences command, read and write phases
`timescale 1ns/1ps
`include "spiMemConfig_config.svh"

module spiMemFsm
    import spiMemPkg::*;
(
    input  logic perEdge,
    input  logic rstN,
    input  logic csLevel,
    input  logic sclkPos,
    input  logic sclkNeg,
    input  logic rwBit,
    output logic shiftEn,
    output logic srLoad,
    output logic addrWe,
    output logic dmWe,
    output logic misoEn
);

    localparam int CntBits = $clog2(`SPI_DATA_BITS);
    localparam logic [CntBits-1:0] LastBit = CntBits'(`SPI_DATA_BITS - 1);

    fsmStateT           state;
    logic [CntBits-1:0] bitCnt;     // sclk rising edges within a byte

    // ------------------------------
    // State and registered strobes
    // ------------------------------
    always_ff @(posedge perEdge or negedge rstN) begin
        if (!rstN) begin
            state  <= getSt;
            bitCnt <= '0;
            addrWe <= 1'b0;
            srLoad <= 1'b0;
            dmWe   <= 1'b0;
            misoEn <= 1'b0;
        end else begin
            addrWe <= 1'b0;     // Strobes last one cycle
            srLoad <= 1'b0;
            dmWe   <= 1'b0;
            if (csLevel) begin
                state  <= getSt;    // Deselect aborts
                bitCnt <= '0;
                misoEn <= 1'b0;
            end else begin
                unique case (state)
                    getSt: begin
                        if (sclkPos) begin
                            bitCnt <= bitCnt + 1'b1;
                            if (bitCnt == LastBit) begin
                                addrWe <= 1'b1;     // Latch address next edge
                                state  <= gotSt;
                            end
                        end
                    end
                    gotSt: begin
                        state <= rwBit ? read1St : write1St;
                    end
                    read1St: begin
                        srLoad <= 1'b1;
                        misoEn <= 1'b1;
                        state  <= read2St;
                    end
                    read2St: begin
                        state <= read3St;
                    end
                    read3St: begin
                        if (sclkPos) begin
                            bitCnt <= bitCnt + 1'b1;
                            if (bitCnt == LastBit) begin
                                state <= doneSt;
                            end
                        end
                    end
                    write1St: begin
                        if (sclkPos) begin
                            bitCnt <= bitCnt + 1'b1;
                            if (bitCnt == LastBit) begin
                                dmWe  <= 1'b1;
                                state <= write2St;
                            end
                        end
                    end
                    write2St: begin
                        state <= doneSt;
                    end
                    doneSt: begin
                        state <= doneSt;    // Left only through csN
                    end
                    default: begin
                        state <= getSt;
                    end
                endcase
            end
        end
    end

    // ------------------------------
    // Shift enable
    // ------------------------------
    // Read data moves on falling edges once the master has sampled bit 7
    always_comb begin
        shiftEn = 1'b0;
        if (!csLevel) begin
            if (state == getSt || state == write1St) begin
                shiftEn = sclkPos;
            end else if (state == read3St) begin
                shiftEn = sclkNeg && (bitCnt != '0);
            end
        end
    end

endmodule

// ==== design/spiMemPkg.sv ====
// Shared address, data and controller state types, imported by the SPI memory RTL
`include "spiMemConfig_config.svh"

package spiMemPkg;

    typedef logic [`SPI_ADDR_BITS-1:0] spiAddrT;
    typedef logic [`SPI_DATA_BITS-1:0] spiDataT;

    // ------------------------------
    // Controller states, one-hot
    // ------------------------------
    typedef enum logic [7:0] {
        getSt    = 8'b0000_0001,    // Shifting in command
        gotSt    = 8'b0000_0010,    // Command complete
        read1St  = 8'b0000_0100,    // Read memory, load shifter
        read2St  = 8'b0000_1000,
        read3St  = 8'b0001_0000,    // Shifting out
        write1St = 8'b0010_0000,    // Shifting in data
        write2St = 8'b0100_0000,    // Write strobe
        doneSt   = 8'b1000_0000     // Wait for csN high
    } fsmStateT;

endpackage

// ==== design/spiMemory.sv ====
// SPI slave memory top, ties pin conditioners, shift register, memory and controller
`timescale 1ns/1ps
`include "spiMemConfig_config.svh"

module spiMemory
    import spiMemPkg::*;
(
    input  logic perEdge,
    input  logic rstN,
    input  logic sclk,
    input  logic csN,
    input  logic mosi,
    output logic miso,
    output logic misoEn
);

    logic    sclkPos;
    logic    sclkNeg;
    logic    csLevel;
    logic    mosiLevel;
    logic    shiftEn;
    logic    srLoad;
    logic    addrWe;
    logic    dmWe;
    spiDataT srParallel;
    spiDataT memReadData;

    // ------------------------------
    // Pin conditioning
    // ------------------------------
    inputConditioner u_sclkCond (
        .perEdge(perEdge), .rstN(rstN), .pin(sclk),
        .level(), .posEdge(sclkPos), .negEdge(sclkNeg)
    );

    inputConditioner u_csCond (
        .perEdge(perEdge), .rstN(rstN), .pin(csN),
        .level(csLevel), .posEdge(), .negEdge()
    );

    inputConditioner u_mosiCond (
        .perEdge(perEdge), .rstN(rstN), .pin(mosi),
        .level(mosiLevel), .posEdge(), .negEdge()
    );

    // ------------------------------
    // Datapath
    // ------------------------------
    shiftRegister u_shift (
        .perEdge(perEdge), .rstN(rstN), .shiftEn(shiftEn), .serialIn(mosiLevel),
        .loadEn(srLoad), .loadData(memReadData), .parallelOut(srParallel),
        .serialOut(miso)
    );

    dataMemory u_mem (
        .perEdge(perEdge), .rstN(rstN), .addrWe(addrWe),
        .addrIn(srParallel[`SPI_DATA_BITS-1 -: `SPI_ADDR_BITS]),   // Command upper bits
        .writeEn(dmWe), .writeData(srParallel), .readData(memReadData)
    );

    spiMemFsm u_fsm (
        .perEdge(perEdge), .rstN(rstN), .csLevel(csLevel), .sclkPos(sclkPos),
        .sclkNeg(sclkNeg), .rwBit(srParallel[0]), .shiftEn(shiftEn),
        .srLoad(srLoad), .addrWe(addrWe), .dmWe(dmWe), .misoEn(misoEn)
    );

endmodule

// ==== sim.f ====
+incdir+design
design/spiMemPkg.sv
design/inputConditioner.sv
design/shiftRegister.sv
design/dataMemory.sv
design/spiMemFsm.sv
design/spiMemory.sv
sim/tbSpiMemory.sv

// ==== sim/tbSpiMemory.sv ====
// Testbench for the SPI slave memory, drives mode 0 frames and checks miso against a memory model
`timescale 1ns/1ps
`include "spiMemConfig_config.svh"

module tbSpiMemory
    import spiMemPkg::*;
();

    localparam int HalfPeriod   = 8;    // perEdge cycles per sclk half
    localparam int DeselTimeout = 20;

    logic        perEdge;
    logic        rstN;
    logic        sclk;
    logic        csN;
    logic        mosi;
    logic        miso;
    logic        misoEn;
    logic [31:0] lfsrState;
    spiDataT     model [`SPI_MEM_DEPTH];

    spiMemory u_dut (
        .perEdge(perEdge), .rstN(rstN), .sclk(sclk), .csN(csN), .mosi(mosi),
        .miso(miso), .misoEn(misoEn)
    );

    initial perEdge = 1'b0;
    always #5 perEdge = ~perEdge;

    // ------------------------------
    // Random source and checks
    // ------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randBits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            val = {val[30:0], lfsrState[0]};    // One step per bit
        end
    endtask

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
            $display("Errors found");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic waitCycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge perEdge);
        end
    endtask

    task automatic waitMisoEnLow();
        int cnt;
        cnt = 0;
        while (misoEn !== 1'b0) begin
            if (cnt == DeselTimeout) begin
                $display("misoEn still high %0d cycles after csN went high", DeselTimeout);
                $display("Errors found");
                $fatal(1, "Timeout waiting for misoEn to drop");
            end else begin
                @(negedge perEdge);
                cnt++;
            end
        end
    endtask

    // ------------------------------
    // SPI master
    // ------------------------------
    task automatic spiBit(input logic outBit, output logic inBit);
        mosi = outBit;
        sclk = 1'b0;
        waitCycles(HalfPeriod);
        inBit = miso;   // Sampled as sclk rises
        sclk  = 1'b1;
        waitCycles(HalfPeriod);
    endtask

    task automatic startFrame();
        csN = 1'b0;
        waitCycles(HalfPeriod);
    endtask

    task automatic endFrame();
        sclk = 1'b0;
        waitCycles(HalfPeriod);
        csN = 1'b1;
        waitMisoEnLow();
        waitCycles(HalfPeriod);     // Idle gap between frames
    endtask

    task automatic sendCommand(input spiAddrT addr, input logic rd);
        logic [`SPI_DATA_BITS-1:0] cmd;
        logic                      unused;
        cmd = {addr, rd};
        for (int i = `SPI_DATA_BITS - 1; i >= 0; i--) begin
            spiBit(cmd[i], unused);
        end
    endtask

    task automatic writeByte(input spiAddrT addr, input spiDataT data);
        logic unused;
        startFrame();
        sendCommand(addr, 1'b0);
        for (int i = `SPI_DATA_BITS - 1; i >= 0; i--) begin
            spiBit(data[i], unused);
        end
        endFrame();
        model[addr] = data;
    endtask

    // Fewer than 8 bits ends the read early
    task automatic readCheck(input spiAddrT addr, input int nBits);
        logic got;
        startFrame();
        sendCommand(addr, 1'b1);
        for (int i = 0; i < nBits; i++) begin
            spiBit(1'b0, got);
            compareValue("misoEn", 1, misoEn);
            compareValue("miso", model[addr][`SPI_DATA_BITS-1-i], got);
        end
        endFrame();
    endtask

    // Drops csN after bitCount bits of a command plus data stream
    task automatic abortWrite(input spiAddrT addr, input spiDataT data, input int bitCount);
        logic [15:0] stream;
        logic        unused;
        stream = {addr, 1'b0, data};
        startFrame();
        for (int i = 0; i < bitCount; i++) begin
            spiBit(stream[15-i], unused);
        end
        endFrame();
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [31:0] r;
        logic        rd;
        spiAddrT     addr;
        lfsrState = 32'h1ecd_5777;
        rstN      = 1'b0;
        sclk      = 1'b0;
        csN       = 1'b1;
        mosi      = 1'b0;
        for (int a = 0; a < `SPI_MEM_DEPTH; a++) begin
            model[a] = '0;
        end
        waitCycles(4);
        rstN = 1'b1;
        waitCycles(4);

        compareValue("misoEn", 0, misoEn);  // Deselected after reset
        for (int a = 0; a < `SPI_MEM_DEPTH; a++) begin
            readCheck(spiAddrT'(a), `SPI_DATA_BITS);
        end
        compareValue("misoEn", 0, misoEn);

        writeByte(7'h55, 8'ha3);
        readCheck(7'h55, `SPI_DATA_BITS);

        repeat (40) begin
            randBits(1, r);
            rd = r[0];
            randBits(`SPI_ADDR_BITS, r);
            addr = spiAddrT'(r);
            if (rd) begin
                readCheck(addr, `SPI_DATA_BITS);
            end else begin
                randBits(`SPI_DATA_BITS, r);
                writeByte(addr, spiDataT'(r));
            end
        end

        writeByte(7'h2a, 8'h3c);
        abortWrite(7'h2a, 8'hc3, 4);    // Inside the command
        readCheck(7'h2a, `SPI_DATA_BITS);
        abortWrite(7'h2a, 8'hc3, 13);   // Inside the data byte
        readCheck(7'h2a, `SPI_DATA_BITS);
        readCheck(7'h2a, 3);            // misoEn must drop mid read

        writeByte(7'h00, 8'hff);
        writeByte(7'h7f, 8'h00);
        readCheck(7'h00, `SPI_DATA_BITS);
        readCheck(7'h7f, `SPI_DATA_BITS);
        writeByte(7'h00, 8'h00);
        writeByte(7'h7f, 8'hff);
        readCheck(7'h00, `SPI_DATA_BITS);
        readCheck(7'h7f, `SPI_DATA_BITS);

        $display("No errors");
        $finish;
    end

endmodule
